// File: common/cache_pkg.sv
// cache geometry
// splits the requester byte address into tag, line index and column,
// and places the valid and dirty flags inside the stored tag word
`default_nettype none

package cache_pkg;

  localparam int ADDR_BITS = 32;
  localparam int WORD_BITS = 32;
  localparam int WORD_BYTES = WORD_BITS / 8;

  // |tag|line|col|00|
  localparam int ZERO_BITS = 2;
  localparam int COLUMN_IX_BITS = 3;
  localparam int LINE_IX_BITS = 4;
  localparam int TAG_BITS = ADDR_BITS - LINE_IX_BITS - COLUMN_IX_BITS - ZERO_BITS;
  localparam int LINE_OFFSET_BITS = COLUMN_IX_BITS + ZERO_BITS;

  localparam int LINE_COUNT = 2 ** LINE_IX_BITS;
  localparam int COLUMN_COUNT = 2 ** COLUMN_IX_BITS;

  // flags sit just above the tag in the tag word
  localparam int LINE_VALID_BIT = TAG_BITS;
  localparam int LINE_DIRTY_BIT = TAG_BITS + 1;

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [WORD_BYTES-1:0] byte_en_t;
  typedef logic [LINE_IX_BITS-1:0] line_ix_t;
  typedef logic [COLUMN_IX_BITS-1:0] column_ix_t;
  typedef logic [TAG_BITS-1:0] tag_t;

endpackage

`default_nettype wire

// File: common/burst_pkg.sv
// burst RAM definitions
// beat width, burst length, command spacing and read latency of the RAM
`default_nettype none

package burst_pkg;

  // memory depth in 64-bit beats
  localparam int RAM_ADDR_BITS = 10;
  localparam int RAM_BEATS = 2 ** RAM_ADDR_BITS;
  localparam int BEAT_BITS = 64;
  localparam int BEAT_BYTE_BITS = $clog2(BEAT_BITS / 8);

  localparam int BURST_BEATS = 4;
  localparam int BEAT_IX_BITS = $clog2(BURST_BEATS);

  // idle cycles between two commands
  localparam int COMMAND_GAP = 13;
  localparam int GAP_CNT_BITS = $clog2(COMMAND_GAP + 1);

  localparam int READ_LATENCY = 4;
  localparam int RD_CNT_BITS = $clog2(READ_LATENCY + BURST_BEATS);

  // each 32-bit half powers up as its byte address xor this
  localparam logic [31:0] INIT_PATTERN = 32'h5A5A_0000;

  typedef logic [RAM_ADDR_BITS-1:0] ram_addr_t;
  typedef logic [BEAT_BITS-1:0] beat_t;
  typedef logic [BEAT_IX_BITS-1:0] beat_ix_t;
  typedef logic [GAP_CNT_BITS-1:0] gap_cnt_t;
  typedef logic [RD_CNT_BITS-1:0] rd_cnt_t;

  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } cmd_e;

endpackage

`default_nettype wire

// File: cache/line_ram.sv
// line storage block
// 16 words with byte-lane writes and a registered read
`timescale 1ns/100ps
`default_nettype none

module line_ram
  import cache_pkg::*;
(
  input wire clk,
  input wire byte_en_t write_enable,
  input wire line_ix_t address,
  input wire word_t data_in,
  output word_t data_out
);

  word_t mem [LINE_COUNT];

  // lines start invalid and clean
  initial begin
    for (int i = 0; i < LINE_COUNT; i++) begin
      mem[i] = '0;
    end
  end

  always @(posedge clk) begin
    for (int b = 0; b < WORD_BYTES; b++) begin
      if (write_enable[b]) begin
        mem[address][b*8 +: 8] <= data_in[b*8 +: 8];
      end
    end
    // read returns the old word when written on the same edge
    data_out <= mem[address];
  end

endmodule

`default_nettype wire

// File: cache/cache.sv
// direct-mapped write-back cache
// serves word reads and byte-masked writes from 16 lines of 8 words,
// fills missing lines from the burst RAM and writes dirty lines back first
`timescale 1ns/100ps
`default_nettype none

module cache
  import cache_pkg::*;
  import burst_pkg::*;
(
  input wire clk,
  input wire rst_n,
  input wire enable,
  input wire addr_t address,
  input wire word_t data_in,
  input wire byte_en_t write_enable,
  input wire beat_t br_rd_data,
  input wire br_rd_data_valid,
  output word_t data_out,
  output logic data_out_ready,
  output logic busy,
  output cmd_e br_cmd,
  output logic br_cmd_en,
  output ram_addr_t br_addr,
  output beat_t br_wr_data
);

  typedef enum logic [5:0] {
    ST_IDLE       = 6'b00_0001,
    ST_EVICT      = 6'b00_0010,
    ST_EVICT_WAIT = 6'b00_0100,
    ST_FILL       = 6'b00_1000,
    ST_FILL_TAG   = 6'b01_0000,
    ST_FILL_DONE  = 6'b10_0000
  } cache_state_e;

  cache_state_e state;

  // address split
  wire column_ix_t column_ix = address[ZERO_BITS +: COLUMN_IX_BITS];
  wire line_ix_t line_ix = address[LINE_OFFSET_BITS +: LINE_IX_BITS];
  wire tag_t address_tag = address[ADDR_BITS-1 -: TAG_BITS];

  logic burst_is_reading;
  logic burst_is_writing;
  gap_cnt_t gap_cnt;
  beat_ix_t beat_ix;
  // line index the block outputs currently belong to
  line_ix_t line_ix_q;

  word_t tag_word;
  byte_en_t tag_we;
  word_t tag_wdata;

  byte_en_t col_we [COLUMN_COUNT];
  word_t col_wdata [COLUMN_COUNT];
  word_t col_rdata [COLUMN_COUNT];

  line_ram tag_ram (
    .clk(clk),
    .write_enable(tag_we),
    .address(line_ix),
    .data_in(tag_wdata),
    .data_out(tag_word)
  );

  for (genvar i = 0; i < COLUMN_COUNT; i++) begin : g_column
    line_ram column_ram (
      .clk(clk),
      .write_enable(col_we[i]),
      .address(line_ix),
      .data_in(col_wdata[i]),
      .data_out(col_rdata[i])
    );
  end

  wire tag_t cached_tag = tag_word[TAG_BITS-1:0];
  wire line_valid = tag_word[LINE_VALID_BIT];
  wire line_dirty = tag_word[LINE_DIRTY_BIT];

  // outputs are one cycle behind the address
  wire lookup_done = line_ix_q == line_ix;
  wire tag_match = line_valid && cached_tag == address_tag;
  wire hit = lookup_done && tag_match;
  wire miss = lookup_done && !tag_match;

  // first beat of the requested line and of the resident line
  wire addr_t fill_byte_addr = {address[ADDR_BITS-1:LINE_OFFSET_BITS],
                                {LINE_OFFSET_BITS{1'b0}}};
  wire addr_t evict_byte_addr = {cached_tag, line_ix, {LINE_OFFSET_BITS{1'b0}}};
  wire ram_addr_t fill_addr = fill_byte_addr[BEAT_BYTE_BITS +: RAM_ADDR_BITS];
  wire ram_addr_t evict_addr = evict_byte_addr[BEAT_BYTE_BITS +: RAM_ADDR_BITS];

  wire start_miss = state == ST_IDLE && enable && miss && gap_cnt == '0;
  wire start_evict = start_miss && line_dirty;
  wire start_fill = (start_miss && !line_dirty) || (state == ST_EVICT_WAIT && gap_cnt == '0);
  wire last_beat = beat_ix == beat_ix_t'(BURST_BEATS - 1);

  assign busy = (enable && !hit) || burst_is_reading || burst_is_writing || gap_cnt != '0;
  assign data_out = col_rdata[column_ix];
  assign data_out_ready = enable && hit && write_enable == '0;

  wire write_hit = enable && hit && !busy && write_enable != '0;

  // column and tag write ports
  always_comb begin
    for (int i = 0; i < COLUMN_COUNT; i++) begin
      col_we[i] = '0;
      col_wdata[i] = data_in;
      if (burst_is_reading) begin
        // even columns take the low half of a beat
        col_wdata[i] = br_rd_data[(i % 2)*WORD_BITS +: WORD_BITS];
        if (state == ST_FILL && br_rd_data_valid && beat_ix == beat_ix_t'(i / 2)) begin
          col_we[i] = '1;
        end
      end else if (write_hit && column_ix == column_ix_t'(i)) begin
        col_we[i] = write_enable;
      end
    end

    tag_wdata = '0;
    tag_wdata[TAG_BITS-1:0] = address_tag;
    tag_wdata[LINE_VALID_BIT] = 1'b1;
    // a fetched line is clean and a write hit marks it dirty
    tag_wdata[LINE_DIRTY_BIT] = state != ST_FILL_TAG;
    tag_we = '0;
    if (state == ST_FILL_TAG || write_hit) begin
      tag_we = '1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      br_cmd_en <= 1'b0;
      burst_is_reading <= 1'b0;
      burst_is_writing <= 1'b0;
      gap_cnt <= '0;
      beat_ix <= '0;
      line_ix_q <= '0;
    end else begin
      line_ix_q <= line_ix;
      br_cmd_en <= 1'b0;
      if (gap_cnt != '0) begin
        gap_cnt <= gap_cnt - 1'b1;
      end
      if (start_evict || start_fill) begin
        br_cmd_en <= 1'b1;
        gap_cnt <= gap_cnt_t'(COMMAND_GAP);
      end

      unique case (state)
        ST_IDLE: begin
          if (start_evict) begin
            // beat 0 goes out with the command
            burst_is_writing <= 1'b1;
            beat_ix <= beat_ix_t'(1);
            state <= ST_EVICT;
          end else if (start_fill) begin
            burst_is_reading <= 1'b1;
            state <= ST_FILL;
          end
        end
        ST_EVICT: begin
          beat_ix <= beat_ix + 1'b1;
          if (last_beat) begin
            state <= ST_EVICT_WAIT;
          end
        end
        ST_EVICT_WAIT: begin
          // read command waits for the gap after the write burst
          if (start_fill) begin
            burst_is_writing <= 1'b0;
            burst_is_reading <= 1'b1;
            state <= ST_FILL;
          end
        end
        ST_FILL: begin
          if (br_rd_data_valid) begin
            beat_ix <= beat_ix + 1'b1;
            if (last_beat) begin
              state <= ST_FILL_TAG;
            end
          end
        end
        ST_FILL_TAG: begin
          state <= ST_FILL_DONE;
        end
        ST_FILL_DONE: begin
          // new tag is on the block output from here on
          burst_is_reading <= 1'b0;
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // command and write beat registers
  always_ff @(posedge clk) begin
    if (start_evict) begin
      br_cmd <= CMD_WRITE;
      br_addr <= evict_addr;
    end else if (start_fill) begin
      br_cmd <= CMD_READ;
      br_addr <= fill_addr;
    end
    // beat_ix already points at the next pair of columns
    br_wr_data <= {col_rdata[{beat_ix, 1'b1}], col_rdata[{beat_ix, 1'b0}]};
  end

endmodule

`default_nettype wire

// File: hdl/burst_ram.sv
// burst RAM model
// four-beat read and write bursts of 64 bits, read data after a fixed latency
`timescale 1ns/100ps
`default_nettype none

module burst_ram
  import burst_pkg::*;
(
  input wire clk,
  input wire rst_n,
  input wire cmd_e cmd,
  input wire cmd_en,
  input wire ram_addr_t addr,
  input wire beat_t wr_data,
  output beat_t rd_data,
  output logic rd_data_valid
);

  beat_t mem [RAM_BEATS];
  ram_addr_t base_addr;

  logic wr_busy;
  beat_ix_t wr_beat;
  logic rd_busy;
  // cycles since the read command
  rd_cnt_t rd_cnt;

  wire rd_streaming = rd_busy && rd_cnt >= rd_cnt_t'(READ_LATENCY - 1);
  wire beat_ix_t rd_beat = beat_ix_t'(rd_cnt - rd_cnt_t'(READ_LATENCY - 1));

  initial begin
    for (int i = 0; i < RAM_BEATS; i++) begin
      mem[i] = {32'(i * (BEAT_BITS / 8) + 4) ^ INIT_PATTERN,
                32'(i * (BEAT_BITS / 8)) ^ INIT_PATTERN};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_busy <= 1'b0;
      wr_beat <= '0;
      rd_busy <= 1'b0;
      rd_cnt <= '0;
      rd_data_valid <= 1'b0;
    end else begin
      rd_data_valid <= rd_streaming;

      // write beat 0 is taken with the command
      if (cmd_en && cmd == CMD_WRITE) begin
        wr_busy <= 1'b1;
        wr_beat <= beat_ix_t'(1);
      end else if (wr_busy) begin
        wr_beat <= wr_beat + 1'b1;
        if (wr_beat == beat_ix_t'(BURST_BEATS - 1)) begin
          wr_busy <= 1'b0;
        end
      end

      if (cmd_en && cmd == CMD_READ) begin
        rd_busy <= 1'b1;
        rd_cnt <= rd_cnt_t'(1);
      end else if (rd_busy) begin
        rd_cnt <= rd_cnt + 1'b1;
        if (rd_cnt == rd_cnt_t'(READ_LATENCY + BURST_BEATS - 2)) begin
          rd_busy <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (cmd_en) begin
      base_addr <= addr;
    end
    if (cmd_en && cmd == CMD_WRITE) begin
      mem[addr] <= wr_data;
    end else if (wr_busy) begin
      mem[base_addr + ram_addr_t'(wr_beat)] <= wr_data;
    end
    // qualified by rd_data_valid
    rd_data <= mem[base_addr + ram_addr_t'(rd_beat)];
  end

endmodule

`default_nettype wire

// File: hdl/cache_system.sv
// cache system top
// the cache in front of the burst RAM
`timescale 1ns/100ps
`default_nettype none

module cache_system
  import cache_pkg::*;
  import burst_pkg::*;
(
  input wire clk,
  input wire rst_n,
  input wire enable,
  input wire addr_t address,
  input wire word_t data_in,
  input wire byte_en_t write_enable,
  output word_t data_out,
  output logic data_out_ready,
  output logic busy
);

  // burst RAM link
  cmd_e br_cmd;
  logic br_cmd_en;
  ram_addr_t br_addr;
  beat_t br_wr_data;
  beat_t br_rd_data;
  logic br_rd_data_valid;

  cache cache0 (
    .clk(clk),
    .rst_n(rst_n),
    .enable(enable),
    .address(address),
    .data_in(data_in),
    .write_enable(write_enable),
    .br_rd_data(br_rd_data),
    .br_rd_data_valid(br_rd_data_valid),
    .data_out(data_out),
    .data_out_ready(data_out_ready),
    .busy(busy),
    .br_cmd(br_cmd),
    .br_cmd_en(br_cmd_en),
    .br_addr(br_addr),
    .br_wr_data(br_wr_data)
  );

  burst_ram ram0 (
    .clk(clk),
    .rst_n(rst_n),
    .cmd(br_cmd),
    .cmd_en(br_cmd_en),
    .addr(br_addr),
    .wr_data(br_wr_data),
    .rd_data(br_rd_data),
    .rd_data_valid(br_rd_data_valid)
  );

endmodule

`default_nettype wire

// File: sim/cache_system_checker.sv
// burst link checker
// watches command pulses and read beats between the cache and the burst RAM
`timescale 1ns/100ps
`default_nettype none

module cache_system_checker
  import burst_pkg::*;
(
  input wire clk,
  input wire rst_n,
  input wire cmd_e cmd,
  input wire cmd_en,
  input wire rd_data_valid
);

  // saturating count of cycles since the last command
  logic [4:0] since_cmd;
  // read beats the RAM still owes
  logic [2:0] beats_owed;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      since_cmd <= '1;
      beats_owed <= '0;
    end else begin
      if (cmd_en) begin
        since_cmd <= 5'd1;
      end else if (since_cmd != '1) begin
        since_cmd <= since_cmd + 1'b1;
      end
      if (cmd_en && cmd == CMD_READ) begin
        beats_owed <= 3'(BURST_BEATS);
      end else if (rd_data_valid && beats_owed != '0) begin
        beats_owed <= beats_owed - 1'b1;
      end
    end
  end

  cmd_pulse_a: assert property (@(posedge clk) disable iff (!rst_n) cmd_en |=> !cmd_en)
    else $error("burst command enable held for more than one cycle");

  cmd_gap_a: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_en |-> since_cmd >= 5'(COMMAND_GAP + 1))
    else $error("burst commands closer together than the command gap");

  rd_beat_a: assert property (@(posedge clk) disable iff (!rst_n)
    rd_data_valid |-> beats_owed != '0)
    else $error("read beat arrived without an earlier read command");

endmodule

bind cache cache_system_checker checker0 (
  .clk(clk),
  .rst_n(rst_n),
  .cmd(br_cmd),
  .cmd_en(br_cmd_en),
  .rd_data_valid(br_rd_data_valid)
);

`default_nettype wire

// File: sim/cache_system_tb.sv
// cache system testbench
// directed and random word accesses checked against a shadow memory
`timescale 1ns/100ps
`default_nettype none

module cache_system_tb
  import cache_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int RANDOM_OPS = 200;
  localparam int OP_COUNT = RANDOM_OPS + 10;
  // power-up RAM content is the byte address xor this
  localparam word_t INIT_XOR = 32'h5A5A_0000;

  logic clk = 1'b0;
  logic rst_n;
  logic enable;
  addr_t address;
  word_t data_in;
  byte_en_t write_enable;
  word_t data_out;
  logic data_out_ready;
  logic busy;

  word_t shadow [addr_t];
  word_t expected_read;
  logic [31:0] lfsr_state = 32'd45;
  int check_count = 0;
  int compare_errors = 0;
  int sequence_errors = 0;

  cache_system dut0 (
    .clk(clk),
    .rst_n(rst_n),
    .enable(enable),
    .address(address),
    .data_in(data_in),
    .write_enable(write_enable),
    .data_out(data_out),
    .data_out_ready(data_out_ready),
    .busy(busy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // word at addr after merging the masked bytes of data
  function automatic word_t expected_word(input addr_t addr, input byte_en_t mask,
                                          input word_t data);
    word_t word;
    word = shadow.exists(addr) ? shadow[addr] : addr ^ INIT_XOR;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        word[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return word;
  endfunction

  // request held until one cycle after busy is seen low
  task automatic access(input addr_t addr, input byte_en_t mask, input word_t data,
                        output int busy_cycles);
    busy_cycles = 0;
    @(posedge clk);
    enable <= 1'b1;
    address <= addr;
    write_enable <= mask;
    data_in <= data;
    @(negedge clk);
    while (busy) begin
      busy_cycles++;
      @(negedge clk);
    end
    if (mask == '0 && !data_out_ready) begin
      sequence_errors++;
      $display("[FAIL] %0t data_out_ready expected 1 got %b (address %h)", $time,
               data_out_ready, addr);
    end
    if (mask != '0) begin
      shadow[addr] = expected_word(addr, mask, data);
    end
    @(posedge clk);
  endtask

  always @(negedge clk) begin
    if (rst_n && data_out_ready && write_enable == '0) begin
      check_count++;
      expected_read = expected_word(address, '0, '0);
      if (data_out !== expected_read) begin
        compare_errors++;
        $display("[FAIL] %0t data_out expected %h got %h (address %h)", $time,
                 expected_read, data_out, address);
      end
    end
  end

  initial begin
    #(OP_COUNT * 200 * CLK_PERIOD);
    $display("timeout, the cache stopped answering requests");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int busy_cycles;
    addr_t addr;
    byte_en_t mask;
    word_t data;
    rst_n <= 1'b0;
    enable <= 1'b0;
    address <= '0;
    data_in <= '0;
    write_enable <= '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    repeat (5) begin
      @(negedge clk);
      if (busy) begin
        sequence_errors++;
        $display("[FAIL] %0t busy expected 0 got %b", $time, busy);
      end
      if (data_out_ready) begin
        sequence_errors++;
        $display("[FAIL] %0t data_out_ready expected 0 got %b", $time, data_out_ready);
      end
    end
    // read miss followed by another column of the same line
    access(32'h0000_0040, '0, '0, busy_cycles);
    access(32'h0000_0054, '0, '0, busy_cycles);
    if (busy_cycles != 0) begin
      sequence_errors++;
      $display("[FAIL] %0t busy cycles expected 0 got %0d", $time, busy_cycles);
    end
    // partial write hit and read back
    access(32'h0000_0054, 4'b0101, 32'hCAFE_F00D, busy_cycles);
    access(32'h0000_0054, '0, '0, busy_cycles);
    // dirty line evicted by another tag and refilled
    access(32'h0000_0120, 4'hF, 32'h1234_5678, busy_cycles);
    access(32'h0000_0320, '0, '0, busy_cycles);
    access(32'h0000_0120, '0, '0, busy_cycles);
    repeat (RANDOM_OPS) begin
      addr = addr_t'(random_bits(10)) << 2;
      mask = (random_bits(1) == 32'd1) ? byte_en_t'(random_bits(4)) : '0;
      data = random_bits(32);
      access(addr, mask, data, busy_cycles);
    end
    @(posedge clk);
    enable <= 1'b0;
    @(negedge clk);
    $display("reads checked %0d, compare errors %0d, sequence errors %0d",
             check_count, compare_errors, sequence_errors);
    if (compare_errors == 0 && sequence_errors == 0 && check_count > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
common/cache_pkg.sv
common/burst_pkg.sv
cache/line_ram.sv
cache/cache.sv
hdl/burst_ram.sv
hdl/cache_system.sv
sim/cache_system_checker.sv
sim/cache_system_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the cache system testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module cache_system_tb \
  -o cache_system_sim &&
{ sim_out="$(./obj_dir/cache_system_sim 2>&1)"; echo "$sim_out"; \
  grep -qx '>>> PASS' <<< "$sim_out"; } &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
